//--- logic/UsiPkg.sv
/* Shared types of the register bus and its GPIO and MIDI slave blocks.
   Modules refer to these by scoped names. */
`default_nettype none

package UsiPkg;

	//------------------------------------------------------------
	// Bus geometry
	//------------------------------------------------------------
	localparam int UsiBlockAdrsWidth = 2;
	localparam int UsiCsrAdrsWidth = 8;
	localparam int UsiDataWidth = 32;

	// Block map with values 2 and 3 unmapped
	typedef enum logic [UsiBlockAdrsWidth-1:0]
	{
		UsiBlkGpio = 2'd0,
		UsiBlkMidi = 2'd1
	} usiBlock_e;

	typedef struct packed
	{
		logic we;
		logic re;
		usiBlock_e block;
		logic [UsiCsrAdrsWidth-1:0] csr;
		logic [UsiDataWidth-1:0] wd;
	} usiReq_t;

	typedef struct packed
	{
		logic [UsiDataWidth-1:0] rd;
		logic vd;
	} usiRsp_t;

	//------------------------------------------------------------
	// CSR offsets per block
	//------------------------------------------------------------
	typedef enum logic [UsiCsrAdrsWidth-1:0]
	{
		GpioCsrOut = 8'd0,
		GpioCsrDir = 8'd1,
		GpioCsrIn = 8'd2
	} gpioCsr_e;

	typedef enum logic [UsiCsrAdrsWidth-1:0]
	{
		MidiCsrCtrl = 8'd0,
		MidiCsrStatus = 8'd1,
		MidiCsrData = 8'd2
	} midiCsr_e;

	// One received MIDI byte with its strobe
	typedef struct packed
	{
		logic [7:0] data;
		logic vd;
	} midiByte_t;

	typedef enum logic [1:0]
	{
		RxIdle,
		RxStart,
		RxData,
		RxStop
	} midiRxState_e;

endpackage

`default_nettype wire

//--- logic/UsiBus.sv
/* Register bus fabric: decodes the block field into slave selects and
   returns the selected block's readback one cycle after a read strobe. */
`default_nettype none

module UsiBus (
	input logic iMCLK,
	input logic qlocked,
	// Request from the bus master
	input UsiPkg::usiReq_t iUsiReq,
	// Block selects
	output logic oGpioSel,
	output logic oMidiSel,
	// Readback from the blocks
	input logic [UsiPkg::UsiDataWidth-1:0] iGpioRd,
	input logic [UsiPkg::UsiDataWidth-1:0] iMidiRd,
	// Response to the bus master
	output UsiPkg::usiRsp_t oUsiRsp
);

logic wStrobe;
logic [UsiPkg::UsiDataWidth-1:0] wRdMux;

//------------------------------------------------------------
// Block decode
//------------------------------------------------------------
assign wStrobe = iUsiReq.we | iUsiReq.re;
assign oGpioSel = wStrobe && (iUsiReq.block == UsiPkg::UsiBlkGpio);
assign oMidiSel = wStrobe && (iUsiReq.block == UsiPkg::UsiBlkMidi);

// Unmapped blocks read as zero
always_comb
begin
	case (iUsiReq.block)
		UsiPkg::UsiBlkGpio: wRdMux = iGpioRd;
		UsiPkg::UsiBlkMidi: wRdMux = iMidiRd;
		default: wRdMux = '0;
	endcase
end

//------------------------------------------------------------
// Response register
//------------------------------------------------------------
always_ff @(posedge iMCLK or negedge qlocked)
begin
	if (!qlocked)
	begin
		oUsiRsp.rd <= '0;
		oUsiRsp.vd <= 1'b0;
	end
	else
	begin
		// Valid is a single-cycle pulse per read
		oUsiRsp.vd <= iUsiReq.re;
		if (iUsiReq.re)
		begin
			oUsiRsp.rd <= wRdMux;
		end
	end
end

endmodule

`default_nettype wire

//--- logic/GpioBlock.sv
/* GPIO slave block: output and direction registers plus synchronized pin
   inputs, all readable over the register bus. */
`default_nettype none

module GpioBlock #(
	parameter int pGpioWidth = 3
) (
	input logic iMCLK,
	input logic qlocked,
	// Bus side
	input logic iSel,
	input UsiPkg::usiReq_t iUsiReq,
	output logic [UsiPkg::UsiDataWidth-1:0] oRd,
	// Pins
	input logic [pGpioWidth-1:0] iGpioIn,
	output logic [pGpioWidth-1:0] oGpioOut,
	output logic [pGpioWidth-1:0] oGpioDir
);

logic [pGpioWidth-1:0] rOut;
logic [pGpioWidth-1:0] rDir;
logic [pGpioWidth-1:0] rInMeta;
logic [pGpioWidth-1:0] rInSync;
logic wWrite;

assign wWrite = iSel & iUsiReq.we;

//------------------------------------------------------------
// Output and direction registers
//------------------------------------------------------------
always_ff @(posedge iMCLK or negedge qlocked)
begin
	if (!qlocked)
	begin
		rOut <= '0;
		rDir <= '0;
	end
	else if (wWrite)
	begin
		case (iUsiReq.csr)
			UsiPkg::GpioCsrOut: rOut <= iUsiReq.wd[pGpioWidth-1:0];
			UsiPkg::GpioCsrDir: rDir <= iUsiReq.wd[pGpioWidth-1:0];
			default: ;
		endcase
	end
end

// Dir 1 drives the pin, 0 leaves it an input
assign oGpioOut = rOut;
assign oGpioDir = rDir;

// Two-flop synchronizer on the pin inputs
always_ff @(posedge iMCLK or negedge qlocked)
begin
	if (!qlocked)
	begin
		rInMeta <= '0;
		rInSync <= '0;
	end
	else
	begin
		rInMeta <= iGpioIn;
		rInSync <= rInMeta;
	end
end

//------------------------------------------------------------
// Readback
//------------------------------------------------------------
always_comb
begin
	oRd = '0;
	case (iUsiReq.csr)
		UsiPkg::GpioCsrOut: oRd[pGpioWidth-1:0] = rOut;
		UsiPkg::GpioCsrDir: oRd[pGpioWidth-1:0] = rDir;
		UsiPkg::GpioCsrIn: oRd[pGpioWidth-1:0] = rInSync;
		default: ;
	endcase
end

endmodule

`default_nettype wire

//--- logic/MidiRx.sv
/* MIDI serial receiver for 8N1 frames, sampling each bit at its centre.
   Reports a byte or a framing error with a one-cycle pulse at the stop bit. */
`default_nettype none

module MidiRx #(
	parameter int pMidiBitCycles = 1600
) (
	input logic iMCLK,
	input logic qlocked,
	input logic iEnable,
	input logic iMidi,
	output UsiPkg::midiByte_t oByte,
	output logic oFrameErr
);

localparam int lpCntWidth = (pMidiBitCycles > 2) ? $clog2(pMidiBitCycles) : 1;
localparam logic [lpCntWidth-1:0] lpFullBit = lpCntWidth'(pMidiBitCycles - 1);
localparam logic [lpCntWidth-1:0] lpHalfBit = lpCntWidth'(pMidiBitCycles / 2 - 1);

UsiPkg::midiRxState_e rState;
logic [2:0] rMidiSh;
logic [lpCntWidth-1:0] rCnt;
logic [2:0] rBitIdx;
logic [7:0] rShift;
logic rByteVd;
logic rFrameErr;
logic wLine;
logic wFall;
logic wTick;

// Bits 0 and 1 synchronize, bit 2 is kept for edge detection
assign wLine = rMidiSh[1];
assign wFall = rMidiSh[2] & ~rMidiSh[1];
assign wTick = (rCnt == '0);

//------------------------------------------------------------
// Frame FSM
//------------------------------------------------------------
always_ff @(posedge iMCLK or negedge qlocked)
begin
	if (!qlocked)
	begin
		rMidiSh <= '1;
		rState <= UsiPkg::RxIdle;
		rCnt <= '0;
		rBitIdx <= '0;
		rByteVd <= 1'b0;
		rFrameErr <= 1'b0;
	end
	else
	begin
		rMidiSh <= {rMidiSh[1:0], iMidi};
		rByteVd <= 1'b0;
		rFrameErr <= 1'b0;
		if (!wTick)
		begin
			rCnt <= rCnt - 1'b1;
		end
		if (!iEnable)
		begin
			rState <= UsiPkg::RxIdle;
		end
		else
		begin
			case (rState)
				UsiPkg::RxIdle:
				begin
					if (wFall)
					begin
						rState <= UsiPkg::RxStart;
						rCnt <= lpHalfBit;
					end
				end
				UsiPkg::RxStart:
				begin
					// A glitch shorter than half a bit is dropped
					if (wTick)
					begin
						rState <= wLine ? UsiPkg::RxIdle : UsiPkg::RxData;
						rCnt <= lpFullBit;
						rBitIdx <= '0;
					end
				end
				UsiPkg::RxData:
				begin
					if (wTick)
					begin
						rCnt <= lpFullBit;
						rBitIdx <= rBitIdx + 1'b1;
						if (rBitIdx == 3'd7)
						begin
							rState <= UsiPkg::RxStop;
						end
					end
				end
				UsiPkg::RxStop:
				begin
					if (wTick)
					begin
						rByteVd <= wLine;
						rFrameErr <= ~wLine;
						rState <= UsiPkg::RxIdle;
					end
				end
				default: rState <= UsiPkg::RxIdle;
			endcase
		end
	end
end

// LSB arrives first
always_ff @(posedge iMCLK)
begin
	if ((rState == UsiPkg::RxData) && wTick)
	begin
		rShift <= {wLine, rShift[7:1]};
	end
end

assign oByte = '{data: rShift, vd: rByteVd};
assign oFrameErr = rFrameErr;

endmodule

`default_nettype wire

//--- logic/MidiCsr.sv
/* MIDI control and status registers: receiver enable, last received byte
   and sticky available, overrun and framing flags. */
`default_nettype none

module MidiCsr (
	input logic iMCLK,
	input logic qlocked,
	// Bus side
	input logic iSel,
	input UsiPkg::usiReq_t iUsiReq,
	output logic [UsiPkg::UsiDataWidth-1:0] oRd,
	// Receiver side
	input UsiPkg::midiByte_t iByte,
	input logic iFrameErr,
	output logic oEnable,
	// Byte stream to the voice logic
	output UsiPkg::midiByte_t oMidiByte
);

logic rEnable;
logic rAvail;
logic rOverrun;
logic rFrame;
logic [7:0] rData;
logic wAccept;
logic wFrameSet;
logic wCtrlWr;
logic wStatusWr;
logic wDataRd;

// Pulses that race a disable are dropped
assign wAccept = iByte.vd & rEnable;
assign wFrameSet = iFrameErr & rEnable;

assign wCtrlWr = iSel && iUsiReq.we && (iUsiReq.csr == UsiPkg::MidiCsrCtrl);
assign wStatusWr = iSel && iUsiReq.we && (iUsiReq.csr == UsiPkg::MidiCsrStatus);
assign wDataRd = iSel && iUsiReq.re && (iUsiReq.csr == UsiPkg::MidiCsrData);

//------------------------------------------------------------
// Control and sticky status
//------------------------------------------------------------
always_ff @(posedge iMCLK or negedge qlocked)
begin
	if (!qlocked)
	begin
		rEnable <= 1'b0;
		rAvail <= 1'b0;
		rOverrun <= 1'b0;
		rFrame <= 1'b0;
	end
	else
	begin
		if (wCtrlWr)
		begin
			rEnable <= iUsiReq.wd[0];
		end
		// Clears first so a new event in the same cycle wins
		if (wStatusWr)
		begin
			if (iUsiReq.wd[0]) rAvail <= 1'b0;
			if (iUsiReq.wd[1]) rOverrun <= 1'b0;
			if (iUsiReq.wd[2]) rFrame <= 1'b0;
		end
		if (wDataRd)
		begin
			rAvail <= 1'b0;
		end
		if (wAccept)
		begin
			rAvail <= 1'b1;
			if (rAvail) rOverrun <= 1'b1;
		end
		if (wFrameSet)
		begin
			rFrame <= 1'b1;
		end
	end
end

always_ff @(posedge iMCLK)
begin
	if (wAccept)
	begin
		rData <= iByte.data;
	end
end

assign oEnable = rEnable;
assign oMidiByte = '{data: iByte.data, vd: wAccept};

//------------------------------------------------------------
// Readback
//------------------------------------------------------------
always_comb
begin
	oRd = '0;
	case (iUsiReq.csr)
		UsiPkg::MidiCsrCtrl: oRd[0] = rEnable;
		UsiPkg::MidiCsrStatus: oRd[2:0] = {rFrame, rOverrun, rAvail};
		UsiPkg::MidiCsrData: oRd[7:0] = rData;
		default: ;
	endcase
end

endmodule

`default_nettype wire

//--- logic/MidiIoTop.sv
/* Top of the register bus subsystem: bus fabric, GPIO block and the MIDI
   receiver with its registers. Bus requests arrive directly on the ports. */
`default_nettype none

module MidiIoTop #(
	parameter int pGpioWidth = 3,
	parameter int pMidiBitCycles = 1600
) (
	input logic iMCLK,
	input logic qlocked,
	// Register bus
	input UsiPkg::usiReq_t iUsiReq,
	output UsiPkg::usiRsp_t oUsiRsp,
	// GPIO pins
	input logic [pGpioWidth-1:0] iGpioIn,
	output logic [pGpioWidth-1:0] oGpioOut,
	output logic [pGpioWidth-1:0] oGpioDir,
	// MIDI line and received bytes
	input logic iMidi,
	output UsiPkg::midiByte_t oMidiByte
);

logic wGpioSel;
logic wMidiSel;
logic [UsiPkg::UsiDataWidth-1:0] wGpioRd;
logic [UsiPkg::UsiDataWidth-1:0] wMidiRd;
UsiPkg::midiByte_t wRxByte;
logic wRxFrameErr;
logic wRxEnable;

//------------------------------------------------------------
// Bus fabric
//------------------------------------------------------------
UsiBus usiBus0 (
	.iMCLK(iMCLK),		.qlocked(qlocked),
	.iUsiReq(iUsiReq),
	.oGpioSel(wGpioSel),	.oMidiSel(wMidiSel),
	.iGpioRd(wGpioRd),	.iMidiRd(wMidiRd),
	.oUsiRsp(oUsiRsp)
);

GpioBlock #(
	.pGpioWidth(pGpioWidth)
) gpioBlock0 (
	.iMCLK(iMCLK),		.qlocked(qlocked),
	.iSel(wGpioSel),	.iUsiReq(iUsiReq),
	.oRd(wGpioRd),
	.iGpioIn(iGpioIn),
	.oGpioOut(oGpioOut),	.oGpioDir(oGpioDir)
);

//------------------------------------------------------------
// MIDI block
//------------------------------------------------------------
MidiRx #(
	.pMidiBitCycles(pMidiBitCycles)
) midiRx0 (
	.iMCLK(iMCLK),		.qlocked(qlocked),
	.iEnable(wRxEnable),	.iMidi(iMidi),
	.oByte(wRxByte),	.oFrameErr(wRxFrameErr)
);

MidiCsr midiCsr0 (
	.iMCLK(iMCLK),		.qlocked(qlocked),
	.iSel(wMidiSel),	.iUsiReq(iUsiReq),
	.oRd(wMidiRd),
	.iByte(wRxByte),	.iFrameErr(wRxFrameErr),
	.oEnable(wRxEnable),	.oMidiByte(oMidiByte)
);

endmodule

`default_nettype wire

//--- testbench/MidiIoTb.sv
/* Testbench for the register bus subsystem. Drives random GPIO and MIDI
   traffic and checks it against a register and serial-line model. */
`default_nettype none

module MidiIoTb;

localparam int lpGpioWidth = 3;
localparam int lpBitCycles = 16;
localparam int lpPeriod = 4;
// Watchdog budget from the frames and bus operations issued below
localparam int lpFrames = 13;
localparam int lpBusOps = 100;
localparam int lpTimeout = (lpFrames * 12 * lpBitCycles + lpBusOps * 10 + 2000) * lpPeriod;

logic iMCLK;
logic qlocked;
UsiPkg::usiReq_t iUsiReq;
UsiPkg::usiRsp_t oUsiRsp;
logic [lpGpioWidth-1:0] iGpioIn;
logic [lpGpioWidth-1:0] oGpioOut;
logic [lpGpioWidth-1:0] oGpioDir;
logic iMidi;
UsiPkg::midiByte_t oMidiByte;

logic [31:0] rngState;
int mismatchCount = 0;
int otherCount = 0;
int pulseCount = 0;
int expCount = 0;

// Expected register state
logic [lpGpioWidth-1:0] modelOut;
logic [lpGpioWidth-1:0] modelDir;
logic modelEnable;
logic modelAvail;
logic modelOverrun;
logic modelFrame;
logic [7:0] modelData;
logic [7:0] expBytes[$];
UsiPkg::midiByte_t expPulse;

MidiIoTop #(
	.pGpioWidth(lpGpioWidth),
	.pMidiBitCycles(lpBitCycles)
) dut0 (
	.iMCLK(iMCLK),
	.qlocked(qlocked),
	.iUsiReq(iUsiReq),
	.oUsiRsp(oUsiRsp),
	.iGpioIn(iGpioIn),
	.oGpioOut(oGpioOut),
	.oGpioDir(oGpioDir),
	.iMidi(iMidi),
	.oMidiByte(oMidiByte)
);

initial
begin
	iMCLK = 1'b0;
	forever #(lpPeriod / 2) iMCLK = ~iMCLK;
end

//------------------------------------------------------------
// Random source and compare tasks
//------------------------------------------------------------
function automatic logic [31:0] nextRandom();
	logic [31:0] x;
	x = rngState;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rngState = x;
	return x;
endfunction

function automatic logic [31:0] gpioWord(input logic [lpGpioWidth-1:0] v);
	return 32'(v);
endfunction

function automatic logic [31:0] statusWord();
	return {29'b0, modelFrame, modelOverrun, modelAvail};
endfunction

task checkUsiRsp(input UsiPkg::usiRsp_t act, input UsiPkg::usiRsp_t exp, input string what);
	if (act !== exp)
	begin
		mismatchCount++;
		$display("MISMATCH at %0t: %s rd %h vd %b, expected rd %h vd %b",
			$time, what, act.rd, act.vd, exp.rd, exp.vd);
	end
endtask

task checkMidiByte(input UsiPkg::midiByte_t act, input UsiPkg::midiByte_t exp,
	input string what);
	if (act !== exp)
	begin
		mismatchCount++;
		$display("MISMATCH at %0t: %s data %h vd %b, expected data %h vd %b",
			$time, what, act.data, act.vd, exp.data, exp.vd);
	end
endtask

task checkGpio(input logic [lpGpioWidth-1:0] act, input logic [lpGpioWidth-1:0] exp,
	input string what);
	if (act !== exp)
	begin
		mismatchCount++;
		$display("MISMATCH at %0t: %s is %b, expected %b", $time, what, act, exp);
	end
endtask

//------------------------------------------------------------
// Bus and serial drivers
//------------------------------------------------------------
task busWrite(input logic [1:0] blk, input logic [7:0] csr, input logic [31:0] wd);
	@(posedge iMCLK);
	#1;
	iUsiReq.we = 1'b1;
	iUsiReq.re = 1'b0;
	iUsiReq.block = UsiPkg::usiBlock_e'(blk);
	iUsiReq.csr = csr;
	iUsiReq.wd = wd;
	@(posedge iMCLK);
	#1;
	iUsiReq.we = 1'b0;
endtask

// Response must be valid exactly one cycle after re, then drop
task busRead(input logic [1:0] blk, input logic [7:0] csr, input logic [31:0] expRd,
	input string what);
	UsiPkg::usiRsp_t expRsp;
	@(posedge iMCLK);
	#1;
	iUsiReq.re = 1'b1;
	iUsiReq.we = 1'b0;
	iUsiReq.block = UsiPkg::usiBlock_e'(blk);
	iUsiReq.csr = csr;
	iUsiReq.wd = nextRandom();
	@(posedge iMCLK);
	#1;
	iUsiReq.re = 1'b0;
	expRsp = '{rd: expRd, vd: 1'b1};
	checkUsiRsp(oUsiRsp, expRsp, what);
	@(posedge iMCLK);
	#1;
	expRsp.vd = 1'b0;
	checkUsiRsp(oUsiRsp, expRsp, {what, " after pulse"});
endtask

task holdBit(input logic b);
	iMidi = b;
	repeat (lpBitCycles) @(posedge iMCLK);
	#1;
endtask

// 8N1 frame sent LSB first and followed by two idle bits
task sendFrame(input logic [7:0] data, input logic stopBit);
	int i;
	@(posedge iMCLK);
	#1;
	holdBit(1'b0);
	for (i = 0; i < 8; i++)
	begin
		holdBit(data[i]);
	end
	holdBit(stopBit);
	holdBit(1'b1);
	holdBit(1'b1);
endtask

task sendModeled(input logic [7:0] data, input logic stopBit);
	if (modelEnable && stopBit)
	begin
		expBytes.push_back(data);
		expCount++;
		if (modelAvail)
		begin
			modelOverrun = 1'b1;
		end
		modelAvail = 1'b1;
		modelData = data;
	end
	else if (modelEnable)
	begin
		modelFrame = 1'b1;
	end
	sendFrame(data, stopBit);
	// A good frame ends with its byte pulse
	wait (pulseCount >= expCount);
endtask

task readStatus();
	busRead(UsiPkg::UsiBlkMidi, UsiPkg::MidiCsrStatus, statusWord(), "MIDI STATUS");
endtask

task readData();
	busRead(UsiPkg::UsiBlkMidi, UsiPkg::MidiCsrData, {24'b0, modelData}, "MIDI DATA");
	modelAvail = 1'b0;
endtask

task writeStatus(input logic [2:0] w);
	busWrite(UsiPkg::UsiBlkMidi, UsiPkg::MidiCsrStatus, {29'b0, w});
	modelAvail = modelAvail & ~w[0];
	modelOverrun = modelOverrun & ~w[1];
	modelFrame = modelFrame & ~w[2];
endtask

task writeCtrl(input logic en);
	busWrite(UsiPkg::UsiBlkMidi, UsiPkg::MidiCsrCtrl, {31'b0, en});
	modelEnable = en;
	busRead(UsiPkg::UsiBlkMidi, UsiPkg::MidiCsrCtrl, {31'b0, en}, "MIDI CTRL");
endtask

//------------------------------------------------------------
// Byte pulse monitor
//------------------------------------------------------------
always @(negedge iMCLK)
begin
	if (oMidiByte.vd === 1'b1)
	begin
		pulseCount++;
		if (expBytes.size() == 0)
		begin
			otherCount++;
			$display("Unexpected MIDI byte pulse at %0t, data %h", $time, oMidiByte.data);
		end
		else
		begin
			expPulse = '{data: expBytes.pop_front(), vd: 1'b1};
			checkMidiByte(oMidiByte, expPulse, "oMidiByte");
		end
	end
end

initial
begin
	#(lpTimeout);
	$display("Timeout at %0t: the run hung before all tests finished", $time);
	$display("Verification failed");
	$finish;
end

//------------------------------------------------------------
// Test sequence
//------------------------------------------------------------
initial
begin
	logic [31:0] r;
	int i;
	rngState = 32'd33423;
	iUsiReq = '0;
	iGpioIn = '0;
	iMidi = 1'b1;
	qlocked = 1'b0;
	modelOut = '0;
	modelDir = '0;
	modelEnable = 1'b0;
	modelAvail = 1'b0;
	modelOverrun = 1'b0;
	modelFrame = 1'b0;
	modelData = '0;
	repeat (5) @(posedge iMCLK);
	#1;
	qlocked = 1'b1;

	// Reset state
	checkGpio(oGpioOut, '0, "oGpioOut after reset");
	checkGpio(oGpioDir, '0, "oGpioDir after reset");
	checkUsiRsp(oUsiRsp, '0, "oUsiRsp after reset");
	busRead(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrOut, '0, "GPIO OUT after reset");
	busRead(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrDir, '0, "GPIO DIR after reset");
	busRead(UsiPkg::UsiBlkMidi, UsiPkg::MidiCsrCtrl, '0, "MIDI CTRL after reset");
	readStatus();

	// GPIO output and direction registers
	for (i = 0; i < 8; i++)
	begin
		r = nextRandom();
		busWrite(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrOut, r);
		modelOut = r[lpGpioWidth-1:0];
		checkGpio(oGpioOut, modelOut, "oGpioOut");
		r = nextRandom();
		busWrite(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrDir, r);
		modelDir = r[lpGpioWidth-1:0];
		checkGpio(oGpioDir, modelDir, "oGpioDir");
		busRead(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrOut, gpioWord(modelOut), "GPIO OUT");
		busRead(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrDir, gpioWord(modelDir), "GPIO DIR");
	end

	// GPIO inputs through the synchronizer
	for (i = 0; i < 6; i++)
	begin
		r = nextRandom();
		@(posedge iMCLK);
		#1;
		iGpioIn = r[lpGpioWidth-1:0];
		repeat (3) @(posedge iMCLK);
		#1;
		busRead(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrIn, gpioWord(iGpioIn), "GPIO IN");
	end

	// OUT holds ones so that a wrong block decode reads back nonzero
	busWrite(UsiPkg::UsiBlkGpio, UsiPkg::GpioCsrOut, 32'hffff_ffff);
	modelOut = '1;
	checkGpio(oGpioOut, modelOut, "oGpioOut");
	busRead(2'd2, UsiPkg::GpioCsrOut, '0, "unmapped block 2");
	busRead(2'd3, UsiPkg::GpioCsrOut, '0, "unmapped block 3");
	for (i = 0; i < 2; i++)
	begin
		busRead(UsiPkg::UsiBlkGpio, 8'(3 + nextRandom() % 253), '0, "GPIO undefined offset");
		busRead(UsiPkg::UsiBlkMidi, 8'(3 + nextRandom() % 253), '0, "MIDI undefined offset");
	end

	// MIDI reception of one byte at a time
	writeCtrl(1'b1);
	for (i = 0; i < 6; i++)
	begin
		r = nextRandom();
		sendModeled(r[7:0], 1'b1);
		repeat (r[12:8]) @(posedge iMCLK);
		readStatus();
		readData();
		readStatus();
	end

	// Overrun from two bytes without a DATA read
	sendModeled(8'(nextRandom()), 1'b1);
	sendModeled(8'(nextRandom()), 1'b1);
	readStatus();
	writeStatus(3'b011);
	readStatus();
	readData();

	// Low stop bit
	sendModeled(8'(nextRandom()), 1'b0);
	readStatus();
	readData();
	writeStatus(3'b100);
	readStatus();

	// Receiver disabled, then enabled again
	writeCtrl(1'b0);
	sendModeled(8'(nextRandom()), 1'b1);
	sendModeled(8'(nextRandom()), 1'b0);
	readStatus();
	readData();
	writeCtrl(1'b1);
	sendModeled(8'(nextRandom()), 1'b1);
	sendModeled(8'(nextRandom()), 1'b1);
	readStatus();
	readData();
	writeStatus(3'b111);
	readStatus();

	repeat (lpBitCycles) @(posedge iMCLK);
	if (expBytes.size() != 0)
	begin
		otherCount++;
		$display("%0d expected MIDI byte pulses never arrived", expBytes.size());
	end
	$display("Mismatches: %0d, other failures: %0d, byte pulses seen: %0d",
		mismatchCount, otherCount, pulseCount);
	if (mismatchCount == 0 && otherCount == 0)
	begin
		$display("Verification passed");
	end
	else
	begin
		$display("Verification failed");
	end
	$finish;
end

endmodule

`default_nettype wire

//--- vlog.f
logic/UsiPkg.sv
logic/UsiBus.sv
logic/GpioBlock.sv
logic/MidiRx.sv
logic/MidiCsr.sv
logic/MidiIoTop.sv
testbench/MidiIoTb.sv

//--- Makefile
SIM = obj_dir/VMidiIoTb
SRCS = $(wildcard logic/*.sv) $(wildcard testbench/*.sv)

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module MidiIoTb -f vlog.f -o VMidiIoTb

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
